/* logic/core_types_pkg.sv */
// core-wide operand word type
// physical register file sizing and index type
// writeback bank and fast-forward pipe selects

package core_types_pkg;

    // operand data
    typedef logic [31:0] word_t;

    // ------------------------------------------------------------------------
    // physical register file

    localparam int PRF_REGS = 16;
    typedef logic [3:0] prf_idx_t;

    // writeback bus banks
    localparam int PRF_BANK_COUNT = 2;
    typedef logic [0:0] bank_idx_t;

    // ------------------------------------------------------------------------
    // fast-forward network

    localparam int FAST_FORWARD_PIPE_COUNT = 4;
    typedef logic [1:0] ff_pipe_t;

endpackage

/* logic/oc_cfg_pkg.sv */
// operand collector depth and pointer types
// occupancy type for the credit counter
// register read latency of the lane

package oc_cfg_pkg;

    // ------------------------------------------------------------------------
    // collector sizing

    localparam int OC_ENTRIES = 4;

    // circular entry pointer, wraps at OC_ENTRIES
    typedef logic [1:0] oc_ptr_t;

    // occupancy, 0 up to OC_ENTRIES
    typedef logic [2:0] oc_count_t;

    // ------------------------------------------------------------------------
    // register file timing

    // cycles from request edge to response capture edge
    localparam int PRF_READ_LATENCY = 2;

endpackage

/* logic/latency_pipe.sv */
// fixed-depth valid/payload shift pipeline
// payload type set by parameter

`timescale 1ns/100ps

module latency_pipe #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     out_valid,
    output payload_t out_payload
);

    logic [DEPTH-1:0] valid_q;
    payload_t         payload_q [DEPTH];

    // valid chain, cleared on reset
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= in_valid;
            for (int unsigned i = 1; i < DEPTH; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // payload chain follows the valid bits
    always_ff @(posedge CLK) begin
        payload_q[0] <= in_payload;
        for (int unsigned i = 1; i < DEPTH; i++) begin
            payload_q[i] <= payload_q[i-1];
        end
    end

    assign out_valid   = valid_q[DEPTH-1];
    assign out_payload = payload_q[DEPTH-1];

endmodule

/* logic/prf_read_port.sv */
// physical register array with one write port
// fixed-latency in-order read port built from two latency pipes

`timescale 1ns/100ps

module prf_read_port (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     wr_valid,
    input  core_types_pkg::prf_idx_t wr_idx,
    input  core_types_pkg::word_t    wr_data,
    input  logic                     rd_req_valid,
    input  core_types_pkg::prf_idx_t rd_req_idx,
    output logic                     reg_read_resp_valid,
    output core_types_pkg::word_t    reg_read_resp_data
);

    core_types_pkg::word_t    regs [core_types_pkg::PRF_REGS];

    logic                     idx_valid;
    core_types_pkg::prf_idx_t idx_q;

    // ------------------------------------------------------------------------
    // register array

    always_ff @(posedge CLK) begin
        if (wr_valid) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // ------------------------------------------------------------------------
    // read path

    // index travels all but the last stage
    latency_pipe #(
        .payload_t (core_types_pkg::prf_idx_t),
        .DEPTH     (oc_cfg_pkg::PRF_READ_LATENCY - 1)
    ) index_pipe_i (
        .CLK         (CLK),
        .nRST        (nRST),
        .in_valid    (rd_req_valid),
        .in_payload  (rd_req_idx),
        .out_valid   (idx_valid),
        .out_payload (idx_q)
    );

    // array word registered in the last stage
    latency_pipe #(
        .payload_t (core_types_pkg::word_t),
        .DEPTH     (1)
    ) word_pipe_i (
        .CLK         (CLK),
        .nRST        (nRST),
        .in_valid    (idx_valid),
        .in_payload  (regs[idx_q]),
        .out_valid   (reg_read_resp_valid),
        .out_payload (reg_read_resp_data)
    );

endmodule

/* logic/oc_credit_counter.sv */
// collector occupancy counter
// enqueue back-pressure from occupancy

`timescale 1ns/100ps

module oc_credit_counter (
    input  logic CLK,
    input  logic nRST,
    input  logic enq_fire,
    input  logic deq_fire,
    output logic enq_ready
);

    oc_cfg_pkg::oc_count_t count_q;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            count_q <= '0;
        end else begin
            case ({enq_fire, deq_fire})
                2'b10: begin
                    count_q <= count_q + oc_cfg_pkg::oc_count_t'(1);
                end
                2'b01: begin
                    count_q <= count_q - oc_cfg_pkg::oc_count_t'(1);
                end
                // both or neither leave occupancy as is
                default: begin
                    count_q <= count_q;
                end
            endcase
        end
    end

    // room for one more entry
    assign enq_ready = (count_q < oc_cfg_pkg::oc_count_t'(oc_cfg_pkg::OC_ENTRIES));

endmodule

/* logic/operand_collector.sv */
// circular operand collector entry array
// register, bus and fast-forward merge by OR
// notify and data dequeue pointers

`timescale 1ns/100ps

module operand_collector (
    input  logic                                                       CLK,
    input  logic                                                       nRST,
    input  logic                                                       enq_valid,
    input  logic                                                       enq_is_reg,
    input  logic                                                       enq_is_bus_forward,
    input  logic                                                       enq_is_fast_forward,
    input  core_types_pkg::ff_pipe_t                                   enq_fast_forward_pipe,
    input  core_types_pkg::bank_idx_t                                  enq_bank,
    input  logic                                                       reg_read_resp_valid,
    input  core_types_pkg::word_t                                      reg_read_resp_data,
    input  core_types_pkg::word_t [core_types_pkg::PRF_BANK_COUNT-1:0] bus_forward_data_by_bank,
    input  logic [core_types_pkg::FAST_FORWARD_PIPE_COUNT-1:0]
        fast_forward_data_valid_by_pipe,
    input  core_types_pkg::word_t [core_types_pkg::FAST_FORWARD_PIPE_COUNT-1:0]
        fast_forward_data_by_pipe,
    output logic                                                       operand_notif_valid,
    input  logic                                                       operand_notif_ack,
    output core_types_pkg::word_t                                      operand_data,
    input  logic                                                       operand_data_ack
);

    localparam int N = oc_cfg_pkg::OC_ENTRIES;

    // control state per entry
    logic [N-1:0] ent_valid;
    logic [N-1:0] need_reg;
    logic [N-1:0] need_bus;
    logic [N-1:0] need_ff;

    // payload per entry
    core_types_pkg::ff_pipe_t  ent_pipe [N];
    core_types_pkg::bank_idx_t ent_bank [N];
    core_types_pkg::word_t     ent_data [N];
    core_types_pkg::word_t     data_next [N];

    oc_cfg_pkg::oc_ptr_t enq_ptr;
    oc_cfg_pkg::oc_ptr_t notif_ptr;
    oc_cfg_pkg::oc_ptr_t data_ptr;

    // register response steering
    oc_cfg_pkg::oc_ptr_t scan_ptr;
    oc_cfg_pkg::oc_ptr_t reg_sel;
    logic                reg_hit;

    logic [N-1:0] reg_take;
    logic [N-1:0] bus_take;
    logic [N-1:0] ff_take;

    // ------------------------------------------------------------------------
    // source capture this edge

    // oldest entry still needing a register, counted from the notify head
    always_comb begin
        reg_hit  = 1'b0;
        reg_sel  = notif_ptr;
        scan_ptr = notif_ptr;
        for (int unsigned k = 0; k < N; k++) begin
            scan_ptr = notif_ptr + oc_cfg_pkg::oc_ptr_t'(k);
            if (!reg_hit && need_reg[scan_ptr]) begin
                reg_hit = 1'b1;
                reg_sel = scan_ptr;
            end
        end
    end

    always_comb begin
        for (int unsigned e = 0; e < N; e++) begin
            reg_take[e] = reg_read_resp_valid && reg_hit &&
                          (reg_sel == oc_cfg_pkg::oc_ptr_t'(e));
            // bus word is only on the wires in the cycle after enqueue
            bus_take[e] = need_bus[e];
            ff_take[e]  = need_ff[e] && fast_forward_data_valid_by_pipe[ent_pipe[e]];

            data_next[e] = ent_data[e];
            if (reg_take[e]) begin
                data_next[e] = data_next[e] | reg_read_resp_data;
            end
            if (bus_take[e]) begin
                data_next[e] = data_next[e] | bus_forward_data_by_bank[ent_bank[e]];
            end
            if (ff_take[e]) begin
                data_next[e] = data_next[e] | fast_forward_data_by_pipe[ent_pipe[e]];
            end
        end
    end

    // ------------------------------------------------------------------------
    // outputs

    // head is ready once every source is in or lands at this edge
    assign operand_notif_valid = ent_valid[notif_ptr] &&
                                 (!need_reg[notif_ptr] || reg_take[notif_ptr]) &&
                                 (!need_ff[notif_ptr] || ff_take[notif_ptr]);

    assign operand_data = ent_data[data_ptr];

    // ------------------------------------------------------------------------
    // entry state

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ent_valid <= '0;
            need_reg  <= '0;
            need_bus  <= '0;
            need_ff   <= '0;
        end else begin
            need_reg <= need_reg & ~reg_take;
            need_bus <= '0;
            need_ff  <= need_ff & ~ff_take;
            if (operand_data_ack) begin
                ent_valid[data_ptr] <= 1'b0;
            end
            // credit counter keeps the enqueue slot free
            if (enq_valid) begin
                ent_valid[enq_ptr] <= 1'b1;
                need_reg[enq_ptr]  <= enq_is_reg;
                need_bus[enq_ptr]  <= enq_is_bus_forward;
                need_ff[enq_ptr]   <= enq_is_fast_forward;
            end
        end
    end

    always_ff @(posedge CLK) begin
        for (int unsigned e = 0; e < N; e++) begin
            ent_data[e] <= data_next[e];
        end
        if (enq_valid) begin
            ent_pipe[enq_ptr] <= enq_fast_forward_pipe;
            ent_bank[enq_ptr] <= enq_bank;
            // zero operand when no source is flagged
            ent_data[enq_ptr] <= '0;
        end
    end

    // pointers
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            enq_ptr   <= '0;
            notif_ptr <= '0;
            data_ptr  <= '0;
        end else begin
            if (enq_valid) begin
                enq_ptr <= enq_ptr + oc_cfg_pkg::oc_ptr_t'(1);
            end
            if (operand_notif_ack) begin
                notif_ptr <= notif_ptr + oc_cfg_pkg::oc_ptr_t'(1);
            end
            if (operand_data_ack) begin
                data_ptr <= data_ptr + oc_cfg_pkg::oc_ptr_t'(1);
            end
        end
    end

endmodule

/* logic/operand_dispatch_fsm.sv */
// dispatch FSM between collector and consumer
// notify acknowledge, then valid/ready send with data acknowledge

`timescale 1ns/100ps

module operand_dispatch_fsm (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  operand_notif_valid,
    output logic                  operand_notif_ack,
    input  core_types_pkg::word_t operand_data,
    output logic                  operand_data_ack,
    output logic                  out_valid,
    output core_types_pkg::word_t out_data,
    input  logic                  out_ready
);

    typedef enum logic {
        IDLE = 1'b0,
        SEND = 1'b1
    } state_t;

    state_t state_q;
    state_t state_next;

    always_comb begin
        state_next        = state_q;
        operand_notif_ack = 1'b0;
        operand_data_ack  = 1'b0;
        case (state_q)
            IDLE: begin
                if (operand_notif_valid) begin
                    operand_notif_ack = 1'b1;
                    state_next        = SEND;
                end
            end
            SEND: begin
                // hold until the consumer takes the word
                if (out_ready) begin
                    operand_data_ack = 1'b1;
                    state_next       = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_next;
        end
    end

    // data head stays put until data_ack
    assign out_valid = (state_q == SEND);
    assign out_data  = operand_data;

endmodule

/* logic/operand_stage.sv */
// operand fetch stage of one issue lane
// register read port, credit counter, collector and dispatch FSM

`timescale 1ns/100ps

module operand_stage (
    input  logic                                                       CLK,
    input  logic                                                       nRST,
    input  logic                                                       enq_valid,
    input  logic                                                       enq_is_reg,
    input  core_types_pkg::prf_idx_t                                   enq_reg_idx,
    input  logic                                                       enq_is_bus_forward,
    input  logic                                                       enq_is_fast_forward,
    input  core_types_pkg::ff_pipe_t                                   enq_fast_forward_pipe,
    input  core_types_pkg::bank_idx_t                                  enq_bank,
    output logic                                                       enq_ready,
    input  logic                                                       wr_valid,
    input  core_types_pkg::prf_idx_t                                   wr_idx,
    input  core_types_pkg::word_t                                      wr_data,
    input  core_types_pkg::word_t [core_types_pkg::PRF_BANK_COUNT-1:0] bus_forward_data_by_bank,
    input  logic [core_types_pkg::FAST_FORWARD_PIPE_COUNT-1:0]
        fast_forward_data_valid_by_pipe,
    input  core_types_pkg::word_t [core_types_pkg::FAST_FORWARD_PIPE_COUNT-1:0]
        fast_forward_data_by_pipe,
    output logic                                                       out_valid,
    output core_types_pkg::word_t                                      out_data,
    input  logic                                                       out_ready
);

    logic                  enq_fire;
    logic                  rd_req_valid;
    logic                  reg_read_resp_valid;
    core_types_pkg::word_t reg_read_resp_data;
    logic                  operand_notif_valid;
    logic                  operand_notif_ack;
    core_types_pkg::word_t operand_data;
    logic                  operand_data_ack;

    assign enq_fire     = enq_valid && enq_ready;
    assign rd_req_valid = enq_fire && enq_is_reg;

    prf_read_port prf_read_port_i (
        .CLK                 (CLK),
        .nRST                (nRST),
        .wr_valid            (wr_valid),
        .wr_idx              (wr_idx),
        .wr_data             (wr_data),
        .rd_req_valid        (rd_req_valid),
        .rd_req_idx          (enq_reg_idx),
        .reg_read_resp_valid (reg_read_resp_valid),
        .reg_read_resp_data  (reg_read_resp_data)
    );

    // entries are freed on data dequeue
    oc_credit_counter oc_credit_counter_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .enq_fire  (enq_fire),
        .deq_fire  (operand_data_ack),
        .enq_ready (enq_ready)
    );

    operand_collector operand_collector_i (
        .CLK                             (CLK),
        .nRST                            (nRST),
        .enq_valid                       (enq_fire),
        .enq_is_reg                      (enq_is_reg),
        .enq_is_bus_forward              (enq_is_bus_forward),
        .enq_is_fast_forward             (enq_is_fast_forward),
        .enq_fast_forward_pipe           (enq_fast_forward_pipe),
        .enq_bank                        (enq_bank),
        .reg_read_resp_valid             (reg_read_resp_valid),
        .reg_read_resp_data              (reg_read_resp_data),
        .bus_forward_data_by_bank        (bus_forward_data_by_bank),
        .fast_forward_data_valid_by_pipe (fast_forward_data_valid_by_pipe),
        .fast_forward_data_by_pipe       (fast_forward_data_by_pipe),
        .operand_notif_valid             (operand_notif_valid),
        .operand_notif_ack               (operand_notif_ack),
        .operand_data                    (operand_data),
        .operand_data_ack                (operand_data_ack)
    );

    operand_dispatch_fsm operand_dispatch_fsm_i (
        .CLK                 (CLK),
        .nRST                (nRST),
        .operand_notif_valid (operand_notif_valid),
        .operand_notif_ack   (operand_notif_ack),
        .operand_data        (operand_data),
        .operand_data_ack    (operand_data_ack),
        .out_valid           (out_valid),
        .out_data            (out_data),
        .out_ready           (out_ready)
    );

endmodule

/* verification/operand_stage_asserts.sv */
// bound protocol checks for the operand stage
// enqueue gating, stalled output stability, register read latency

`timescale 1ns/100ps

module operand_stage_asserts (
    input logic                  CLK,
    input logic                  nRST,
    input logic                  enq_fire,
    input logic                  collector_full,
    input logic                  out_valid,
    input core_types_pkg::word_t out_data,
    input logic                  out_ready,
    input logic                  rd_req_valid,
    input logic                  reg_read_resp_valid
);

    int fail_count = 0;

    // no transfer into a full collector
    enq_gated: assert property (@(posedge CLK) disable iff (!nRST)
        enq_fire |-> !collector_full)
        else begin
            $error("enqueue transfer into a full collector");
            fail_count++;
        end

    // stalled output holds its word
    out_hold: assert property (@(posedge CLK) disable iff (!nRST)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else begin
            $error("out_valid or out_data changed while stalled");
            fail_count++;
        end

    // every request answered after the fixed latency
    read_latency: assert property (@(posedge CLK) disable iff (!nRST)
        rd_req_valid |-> ##(oc_cfg_pkg::PRF_READ_LATENCY) reg_read_resp_valid)
        else begin
            $error("register read response missing at fixed latency");
            fail_count++;
        end

    // no response without a request
    read_no_stray: assert property (@(posedge CLK) disable iff (!nRST)
        reg_read_resp_valid |-> $past(rd_req_valid, oc_cfg_pkg::PRF_READ_LATENCY))
        else begin
            $error("register read response without matching request");
            fail_count++;
        end

endmodule

/* verification/operand_stage_tb.sv */
// testbench for the operand fetch stage
// clock, reset, stimulus tasks, reference function and output checker

`timescale 1ns/100ps

module operand_stage_tb;

    localparam int WAIT_LIMIT  = 200;
    localparam int RANDOM_OPS  = 200;
    localparam int PATTERN_LEN = 4096;

    logic                                                       CLK;
    logic                                                       nRST;
    logic                                                       enq_valid;
    logic                                                       enq_is_reg;
    core_types_pkg::prf_idx_t                                   enq_reg_idx;
    logic                                                       enq_is_bus_forward;
    logic                                                       enq_is_fast_forward;
    core_types_pkg::ff_pipe_t                                   enq_fast_forward_pipe;
    core_types_pkg::bank_idx_t                                  enq_bank;
    logic                                                       enq_ready;
    logic                                                       wr_valid;
    core_types_pkg::prf_idx_t                                   wr_idx;
    core_types_pkg::word_t                                      wr_data;
    core_types_pkg::word_t [core_types_pkg::PRF_BANK_COUNT-1:0] bus_forward_data_by_bank;
    logic [core_types_pkg::FAST_FORWARD_PIPE_COUNT-1:0]         fast_forward_data_valid_by_pipe;
    core_types_pkg::word_t [core_types_pkg::FAST_FORWARD_PIPE_COUNT-1:0]
        fast_forward_data_by_pipe;
    logic                                                       out_valid;
    core_types_pkg::word_t                                      out_data;
    logic                                                       out_ready;

    // reference state
    core_types_pkg::word_t prf_model [core_types_pkg::PRF_REGS];
    core_types_pkg::word_t ff_word [core_types_pkg::FAST_FORWARD_PIPE_COUNT];
    core_types_pkg::word_t exp_q [$];
    core_types_pkg::word_t cmp_expected;
    logic                  ready_pattern [PATTERN_LEN];
    logic                  ready_now;
    int                    seed;
    int                    ready_mode;
    int                    cycle_count;

    operand_stage operand_stage_i (.*);

    bind operand_stage operand_stage_asserts asserts_i (
        .CLK                 (CLK),
        .nRST                (nRST),
        .enq_fire            (enq_fire),
        .collector_full      (&operand_collector_i.ent_valid),
        .out_valid           (out_valid),
        .out_data            (out_data),
        .out_ready           (out_ready),
        .rd_req_valid        (rd_req_valid),
        .reg_read_resp_valid (reg_read_resp_valid)
    );

    always #10 CLK = ~CLK;

    // ------------------------------------------------------------------------
    // reference model and helpers

    function automatic core_types_pkg::word_t expected_operand(
        input logic                      is_reg,
        input core_types_pkg::prf_idx_t  idx,
        input logic                      is_bus,
        input core_types_pkg::bank_idx_t bank,
        input logic                      is_ff,
        input core_types_pkg::word_t     pipe_word
    );
        core_types_pkg::word_t result;
        result = '0;
        if (is_reg) begin
            result = result | prf_model[idx];
        end
        if (is_bus) begin
            result = result | bus_forward_data_by_bank[bank];
        end
        if (is_ff) begin
            result = result | pipe_word;
        end
        return result;
    endfunction

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("ERROR: %0t %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic write_prf(input core_types_pkg::prf_idx_t idx,
                             input core_types_pkg::word_t data);
        wr_valid = 1'b1;
        wr_idx = idx;
        wr_data = data;
        prf_model[idx] = data;
        @(posedge CLK);
        #2;
        wr_valid = 1'b0;
    endtask

    // fresh register words and bus words for the next batch
    task automatic preload_batch();
        for (int i = 0; i < core_types_pkg::PRF_REGS; i++) begin
            write_prf(core_types_pkg::prf_idx_t'(i), $random(seed));
        end
        for (int b = 0; b < core_types_pkg::PRF_BANK_COUNT; b++) begin
            bus_forward_data_by_bank[b] = $random(seed);
        end
    endtask

    task automatic enqueue_op(input logic is_reg, input core_types_pkg::prf_idx_t idx,
                              input logic is_bus, input core_types_pkg::bank_idx_t bank,
                              input logic is_ff, input core_types_pkg::ff_pipe_t pipe);
        int waited;
        waited = 0;
        enq_valid = 1'b1;
        enq_is_reg = is_reg;
        enq_reg_idx = idx;
        enq_is_bus_forward = is_bus;
        enq_bank = bank;
        enq_is_fast_forward = is_ff;
        enq_fast_forward_pipe = pipe;
        if (is_ff) begin
            ff_word[pipe] = $random(seed);
        end
        exp_q.push_back(expected_operand(is_reg, idx, is_bus, bank, is_ff, ff_word[pipe]));
        while (!enq_ready) begin
            @(posedge CLK);
            #2;
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("enq_ready stayed low for %0d cycles", waited);
                stop_run();
            end
        end
        @(posedge CLK);
        #2;
        enq_valid = 1'b0;
    endtask

    task automatic pulse_pipe(input core_types_pkg::ff_pipe_t pipe);
        fast_forward_data_valid_by_pipe[pipe] = 1'b1;
        fast_forward_data_by_pipe[pipe] = ff_word[pipe];
        @(posedge CLK);
        #2;
        fast_forward_data_valid_by_pipe[pipe] = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge CLK);
            #2;
            waited++;
            if (waited > WAIT_LIMIT * 8) begin
                $display("%0d expected words never came out", exp_q.size());
                stop_run();
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // consumer ready and output checker

    // mode 0 holds low, 1 holds high, 2 follows the random pattern
    always @(posedge CLK) begin
        ready_now = (ready_mode == 2) ? ready_pattern[cycle_count % PATTERN_LEN]
                                      : (ready_mode == 1);
        cycle_count++;
        #2;
        out_ready = ready_now;
    end

    // transfer completes at the next rising edge
    always @(negedge CLK) begin
        if (nRST && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("output word arrived with no expected value");
                stop_run();
            end else begin
                cmp_expected = exp_q.pop_front();
                assert (out_data === cmp_expected) else begin
                    $display("ERROR: %0t out_data got %h expected %h",
                             $time, out_data, cmp_expected);
                    stop_run();
                end
            end
        end
        if (operand_stage_i.asserts_i.fail_count != 0) begin
            $display("a bound protocol assertion failed");
            stop_run();
        end
    end

    // ------------------------------------------------------------------------
    // test sequence

    initial begin
        logic [31:0] r;
        seed = 68;
        CLK = 1'b0;
        nRST = 1'b0;
        enq_valid = 1'b0;
        enq_is_reg = 1'b0;
        enq_reg_idx = '0;
        enq_is_bus_forward = 1'b0;
        enq_is_fast_forward = 1'b0;
        enq_fast_forward_pipe = '0;
        enq_bank = '0;
        wr_valid = 1'b0;
        wr_idx = '0;
        wr_data = '0;
        bus_forward_data_by_bank = '0;
        fast_forward_data_valid_by_pipe = '0;
        fast_forward_data_by_pipe = '0;
        out_ready = 1'b0;
        ready_mode = 0;
        cycle_count = 0;
        for (int i = 0; i < PATTERN_LEN; i++) begin
            r = $random(seed);
            ready_pattern[i] = r[0];
        end
        repeat (5) @(posedge CLK);
        #2;
        nRST = 1'b1;
        @(posedge CLK);
        #2;
        check_bit("enq_ready", enq_ready, 1'b1);
        check_bit("out_valid", out_valid, 1'b0);

        // register, bus, zero and mixed operands
        ready_mode = 1;
        preload_batch();
        enqueue_op(1'b1, 4'd3, 1'b0, 1'b0, 1'b0, 2'd0);
        enqueue_op(1'b0, 4'd0, 1'b1, 1'b1, 1'b0, 2'd0);
        enqueue_op(1'b0, 4'd0, 1'b0, 1'b0, 1'b0, 2'd0);
        enqueue_op(1'b1, 4'd9, 1'b1, 1'b0, 1'b0, 2'd0);
        wait_drain();

        // fast-forward head blocks younger entries until its pipe fires
        preload_batch();
        enqueue_op(1'b0, 4'd0, 1'b0, 1'b0, 1'b1, 2'd1);
        enqueue_op(1'b1, 4'd5, 1'b1, 1'b1, 1'b1, 2'd2);
        enqueue_op(1'b1, 4'd7, 1'b0, 1'b0, 1'b0, 2'd0);
        enqueue_op(1'b0, 4'd0, 1'b1, 1'b0, 1'b0, 2'd0);
        repeat (6) begin
            @(posedge CLK);
            #2;
            check_bit("out_valid", out_valid, 1'b0);
        end
        pulse_pipe(2'd2);
        check_bit("out_valid", out_valid, 1'b0);
        pulse_pipe(2'd1);
        wait_drain();

        // back-pressure with the consumer stalled
        ready_mode = 0;
        preload_batch();
        for (int i = 0; i < oc_cfg_pkg::OC_ENTRIES; i++) begin
            enqueue_op(1'b1, core_types_pkg::prf_idx_t'(i * 3), 1'b0, 1'b0, 1'b0, 2'd0);
        end
        check_bit("enq_ready", enq_ready, 1'b0);
        ready_mode = 1;
        enqueue_op(1'b1, 4'd15, 1'b1, 1'b1, 1'b0, 2'd0);
        wait_drain();

        // random mix with random consumer stalls
        preload_batch();
        ready_mode = 2;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            r = $random(seed);
            enqueue_op(r[0], r[7:4], r[1], r[8], r[2] & r[3], r[10:9]);
            if (r[2] & r[3]) begin
                pulse_pipe(r[10:9]);
            end
        end
        wait_drain();

        if (exp_q.size() == 0 && operand_stage_i.asserts_i.fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* flist.f */
logic/core_types_pkg.sv
logic/oc_cfg_pkg.sv
logic/latency_pipe.sv
logic/prf_read_port.sv
logic/oc_credit_counter.sv
logic/operand_collector.sv
logic/operand_dispatch_fsm.sv
logic/operand_stage.sv
verification/operand_stage_asserts.sv
verification/operand_stage_tb.sv
